//--- src/rvCorePkg.sv
package rvCorePkg;

	localparam int xlen = 32;

	localparam logic [6:0] opcodeOpImm = 7'b0010011;
	localparam logic [6:0] opcodeOp = 7'b0110011;
	localparam logic [6:0] opcodeLui = 7'b0110111;
	localparam logic [6:0] opcodeAuipc = 7'b0010111;

	// Management address map
	localparam logic [15:0] addrControl = 16'h0000;
	localparam logic [15:0] addrProgramCounter = 16'h0004;
	localparam logic [15:0] addrInstruction = 16'h0008;
	localparam logic [15:0] addrRegisterBase = 16'h0100;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rType;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iType;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uType;

	typedef union packed {
		rType r;
		iType i;
		uType u;
	} instructionWord;

	typedef struct packed {
		logic [xlen-1:0] pc;
		instructionWord instruction;
	} fetchEntry;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [15:0] paddr;
		logic [xlen-1:0] pwdata;
		logic [3:0] pstrb;
	} apbRequest;

	typedef struct packed {
		logic [xlen-1:0] prdata;
		logic pslverr;
	} apbResponse;

	typedef struct packed {
		logic run;
		logic step;
		logic pcWrite;
		logic [xlen-1:0] pcData;
	} fetchControl;

	typedef struct packed {
		logic write;
		logic [4:0] index;
		logic [xlen-1:0] data;
	} regAccess;

	typedef struct packed {
		logic raise;
		logic [xlen-1:0] pc;
	} errorReport;

endpackage

//--- src/managementPort.sv
module managementPort import rvCorePkg::*; (
	input logic clk,
	input logic rst,
	input apbRequest apbIn,
	output apbResponse apbOut,
	output fetchControl control,
	output regAccess regWrite,
	output logic [4:0] regReadIndex,
	input logic [xlen-1:0] regReadData,
	input logic [xlen-1:0] fetchPc,
	input logic fetchBusy,
	input logic queueEmpty,
	input logic [xlen-1:0] lastInstruction,
	input errorReport error
);

	logic runFlag;
	logic stepPending;
	logic errorFlag;
	logic halted;
	logic access;
	logic selControl;
	logic selPc;
	logic selInstruction;
	logic selRegister;
	logic badAccess;
	logic controlWrite;

	function automatic logic [xlen-1:0] mergeBytes(
		input logic [xlen-1:0] current,
		input logic [xlen-1:0] data,
		input logic [3:0] strobe
	);
		logic [xlen-1:0] merged;
		merged = current;
		for (int i = 0; i < 4; i++) begin
			if (strobe[i])
				merged[8*i +: 8] = data[8*i +: 8];
		end
		return merged;
	endfunction

	assign access = apbIn.psel && apbIn.penable;
	assign halted = !runFlag && !stepPending && !fetchBusy && queueEmpty;

	assign selControl = apbIn.paddr == addrControl;
	assign selPc = apbIn.paddr == addrProgramCounter;
	assign selInstruction = apbIn.paddr == addrInstruction;
	// 32 word-aligned registers from the base
	assign selRegister = (apbIn.paddr[15:7] == addrRegisterBase[15:7]) && (apbIn.paddr[1:0] == 2'b00);

	always_comb begin
		badAccess = 1'b0;
		if (!(selControl || selPc || selInstruction || selRegister))
			badAccess = 1'b1;
		else if ((selPc || selInstruction || selRegister) && !halted)
			badAccess = 1'b1;
		else if (selControl && apbIn.pwrite && apbIn.pstrb[0] && apbIn.pwdata[0] && errorFlag)
			badAccess = 1'b1;
	end

	assign controlWrite = access && apbIn.pwrite && selControl && apbIn.pstrb[0] && !badAccess;

	always_ff @(posedge clk) begin
		if (rst) begin
			runFlag <= 1'b0;
			stepPending <= 1'b0;
			errorFlag <= 1'b0;
		end else begin
			// Step lasts one cycle, the fetch unit keeps it armed
			stepPending <= controlWrite && apbIn.pwdata[1] && !apbIn.pwdata[0] && !runFlag;
			if (controlWrite) begin
				runFlag <= apbIn.pwdata[0];
				if (apbIn.pwdata[2])
					errorFlag <= 1'b0;
			end
			if (error.raise) begin
				runFlag <= 1'b0;
				errorFlag <= 1'b1;
			end
		end
	end

	assign regReadIndex = apbIn.paddr[6:2];

	assign control.run = runFlag;
	assign control.step = stepPending;
	assign control.pcWrite = access && apbIn.pwrite && selPc && !badAccess;
	assign control.pcData = mergeBytes(fetchPc, apbIn.pwdata, apbIn.pstrb);

	assign regWrite.write = access && apbIn.pwrite && selRegister && !badAccess;
	assign regWrite.index = apbIn.paddr[6:2];
	assign regWrite.data = mergeBytes(regReadData, apbIn.pwdata, apbIn.pstrb);

	always_comb begin
		apbOut.prdata = '0;
		if (!badAccess) begin
			if (selControl)
				apbOut.prdata = {{(xlen-3){1'b0}}, errorFlag, halted, runFlag};
			else if (selPc)
				apbOut.prdata = fetchPc;
			else if (selInstruction)
				apbOut.prdata = lastInstruction;
			else
				apbOut.prdata = regReadData;
		end
	end

	assign apbOut.pslverr = access && badAccess;

endmodule

//--- src/fetchUnit.sv
module fetchUnit import rvCorePkg::*; #(
	parameter logic [xlen-1:0] resetVector = '0
) (
	input logic clk,
	input logic rst,
	input fetchControl control,
	input errorReport error,
	input logic queueFull,
	output logic [xlen-1:0] imemAddress,
	output logic imemEnable,
	input logic [xlen-1:0] imemData,
	input logic imemBusy,
	output logic push,
	output fetchEntry pushEntry,
	output logic [xlen-1:0] fetchPc,
	output logic fetchBusy
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] requestAddress;
	logic requestActive;
	logic discard;
	logic stepArmed;
	logic issue;
	logic complete;

	assign complete = requestActive && !imemBusy;
	assign issue = !requestActive && !queueFull && (control.run || stepArmed) && !error.raise;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= resetVector;
			requestActive <= 1'b0;
			discard <= 1'b0;
			stepArmed <= 1'b0;
		end else begin
			if (issue)
				requestActive <= 1'b1;
			else if (complete)
				requestActive <= 1'b0;

			// Redirect mid-flight, drop the word when it arrives
			if (error.raise && requestActive && !complete)
				discard <= 1'b1;
			else if (complete)
				discard <= 1'b0;

			if (error.raise)
				stepArmed <= 1'b0;
			else if (control.step)
				stepArmed <= 1'b1;
			else if (issue)
				stepArmed <= 1'b0;

			if (error.raise)
				pc <= error.pc;
			else if (control.pcWrite)
				pc <= control.pcData;
			else if (complete && !discard)
				pc <= pc + 32'd4;
		end
	end

	// Address held stable while the request is outstanding
	always_ff @(posedge clk) begin
		if (issue)
			requestAddress <= pc;
	end

	assign imemAddress = requestAddress;
	assign imemEnable = requestActive;

	assign push = complete && !discard && !error.raise;
	assign pushEntry.pc = requestAddress;
	assign pushEntry.instruction = imemData;

	assign fetchPc = pc;
	assign fetchBusy = requestActive || stepArmed;

endmodule

//--- src/instructionQueue.sv
module instructionQueue import rvCorePkg::*; #(
	parameter int queueDepth = 2
) (
	input logic clk,
	input logic rst,
	input logic push,
	input fetchEntry pushEntry,
	input logic pop,
	input logic flush,
	output fetchEntry head,
	output logic empty,
	output logic full
);

	localparam int pointerWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int countWidth = $clog2(queueDepth + 1);

	fetchEntry storage [queueDepth];
	logic [pointerWidth-1:0] readPointer;
	logic [pointerWidth-1:0] writePointer;
	logic [countWidth-1:0] count;
	logic doPush;
	logic doPop;

	assign empty = count == '0;
	assign full = count == countWidth'(queueDepth);
	assign doPop = pop && !empty;
	// A full queue still takes a word when the head leaves
	assign doPush = push && (!full || doPop);

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			readPointer <= '0;
			writePointer <= '0;
			count <= '0;
		end else begin
			if (doPush)
				writePointer <= (writePointer == pointerWidth'(queueDepth - 1)) ? '0 : writePointer + 1'b1;
			if (doPop)
				readPointer <= (readPointer == pointerWidth'(queueDepth - 1)) ? '0 : readPointer + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (doPush && !flush)
			storage[writePointer] <= pushEntry;
	end

	assign head = storage[readPointer];

endmodule

//--- src/executeUnit.sv
module executeUnit import rvCorePkg::*; (
	input logic clk,
	input logic rst,
	input fetchEntry head,
	input logic empty,
	output logic pop,
	input regAccess regWrite,
	input logic [4:0] regReadIndex,
	output logic [xlen-1:0] regReadData,
	output logic [xlen-1:0] lastInstruction,
	output errorReport error
);

	logic [xlen-1:0] registers [32];
	instructionWord word;
	logic isOpImm;
	logic isOp;
	logic isLui;
	logic isAuipc;
	logic valid;
	logic altFunct;
	logic [xlen-1:0] rs1Data;
	logic [xlen-1:0] rs2Data;
	logic [xlen-1:0] operandB;
	logic [xlen-1:0] upperImm;
	logic [4:0] shamt;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] result;
	logic rdWrite;

	assign pop = !empty;
	assign word = head.instruction;

	assign isOpImm = word.r.opcode == opcodeOpImm;
	assign isOp = word.r.opcode == opcodeOp;
	assign isLui = word.r.opcode == opcodeLui;
	assign isAuipc = word.r.opcode == opcodeAuipc;

	// funct7 bit 5 picks SUB and the arithmetic shifts
	assign altFunct = word.r.funct7 == 7'b0100000;

	always_comb begin
		valid = 1'b0;
		if (isLui || isAuipc) begin
			valid = 1'b1;
		end else if (isOpImm) begin
			case (word.i.funct3)
				3'b001: valid = word.r.funct7 == 7'b0000000;
				3'b101: valid = (word.r.funct7 == 7'b0000000) || altFunct;
				default: valid = 1'b1;
			endcase
		end else if (isOp) begin
			if (word.r.funct7 == 7'b0000000)
				valid = 1'b1;
			else if (altFunct)
				valid = (word.r.funct3 == 3'b000) || (word.r.funct3 == 3'b101);
		end
	end

	assign rs1Data = (word.r.rs1 == 5'd0) ? '0 : registers[word.r.rs1];
	assign rs2Data = (word.r.rs2 == 5'd0) ? '0 : registers[word.r.rs2];
	assign operandB = isOp ? rs2Data : {{(xlen-12){word.i.imm[11]}}, word.i.imm};
	assign shamt = operandB[4:0];
	assign upperImm = {word.u.imm, 12'b0};

	always_comb begin
		case (word.r.funct3)
			3'b000: aluResult = (isOp && altFunct) ? rs1Data - operandB : rs1Data + operandB;
			3'b001: aluResult = rs1Data << shamt;
			3'b010: aluResult = {{(xlen-1){1'b0}}, $signed(rs1Data) < $signed(operandB)};
			3'b011: aluResult = {{(xlen-1){1'b0}}, rs1Data < operandB};
			3'b100: aluResult = rs1Data ^ operandB;
			3'b101: begin
				if (word.r.funct7[5])
					aluResult = $signed(rs1Data) >>> shamt;
				else
					aluResult = rs1Data >> shamt;
			end
			3'b110: aluResult = rs1Data | operandB;
			default: aluResult = rs1Data & operandB;
		endcase
	end

	always_comb begin
		if (isLui)
			result = upperImm;
		else if (isAuipc)
			result = head.pc + upperImm;
		else
			result = aluResult;
	end

	assign rdWrite = pop && valid && (word.r.rd != 5'd0);

	// Management writes only land while the queue is drained
	always_ff @(posedge clk) begin
		if (rdWrite)
			registers[word.r.rd] <= result;
		else if (regWrite.write && (regWrite.index != 5'd0))
			registers[regWrite.index] <= regWrite.data;
	end

	always_ff @(posedge clk) begin
		if (rst)
			lastInstruction <= '0;
		else if (pop)
			lastInstruction <= word;
	end

	assign regReadData = (regReadIndex == 5'd0) ? '0 : registers[regReadIndex];

	assign error.raise = pop && !valid;
	assign error.pc = head.pc;

endmodule

//--- src/rvCore.sv
module rvCore import rvCorePkg::*; #(
	parameter logic [xlen-1:0] resetVector = '0,
	parameter int queueDepth = 2
) (
	input logic clk,
	input logic rst,
	input apbRequest apbIn,
	output apbResponse apbOut,
	output logic [xlen-1:0] imemAddress,
	output logic imemEnable,
	input logic [xlen-1:0] imemData,
	input logic imemBusy
);

	fetchControl control;
	regAccess regWrite;
	errorReport error;
	fetchEntry pushEntry;
	fetchEntry head;
	logic [4:0] regReadIndex;
	logic [xlen-1:0] regReadData;
	logic [xlen-1:0] fetchPc;
	logic [xlen-1:0] lastInstruction;
	logic fetchBusy;
	logic queueEmpty;
	logic queueFull;
	logic push;
	logic pop;

	managementPort management_i (
		.clk(clk),
		.rst(rst),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.control(control),
		.regWrite(regWrite),
		.regReadIndex(regReadIndex),
		.regReadData(regReadData),
		.fetchPc(fetchPc),
		.fetchBusy(fetchBusy),
		.queueEmpty(queueEmpty),
		.lastInstruction(lastInstruction),
		.error(error)
	);

	fetchUnit #(
		.resetVector(resetVector)
	) fetch_i (
		.clk(clk),
		.rst(rst),
		.control(control),
		.error(error),
		.queueFull(queueFull),
		.imemAddress(imemAddress),
		.imemEnable(imemEnable),
		.imemData(imemData),
		.imemBusy(imemBusy),
		.push(push),
		.pushEntry(pushEntry),
		.fetchPc(fetchPc),
		.fetchBusy(fetchBusy)
	);

	// Invalid instruction flushes everything fetched behind it
	instructionQueue #(
		.queueDepth(queueDepth)
	) queue_i (
		.clk(clk),
		.rst(rst),
		.push(push),
		.pushEntry(pushEntry),
		.pop(pop),
		.flush(error.raise),
		.head(head),
		.empty(queueEmpty),
		.full(queueFull)
	);

	executeUnit execute_i (
		.clk(clk),
		.rst(rst),
		.head(head),
		.empty(queueEmpty),
		.pop(pop),
		.regWrite(regWrite),
		.regReadIndex(regReadIndex),
		.regReadData(regReadData),
		.lastInstruction(lastInstruction),
		.error(error)
	);

endmodule

//--- bench/instructionMemoryModel.sv
module instructionMemoryModel #(
	parameter int depth = 256,
	parameter logic [31:0] seed = 32'hf6ca
) (
	input logic clk,
	input logic [31:0] address,
	input logic enable,
	output logic [31:0] data,
	output logic busy
);

	localparam int indexWidth = $clog2(depth);

	logic [31:0] rom [depth];
	logic [31:0] lfsr;
	logic [indexWidth-1:0] wordIndex;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	initial begin
		lfsr = seed;
		data = '0;
		busy = 1'b0;
		// Unused words carry their own index
		for (int i = 0; i < depth; i++)
			rom[i] = 32'hfeed0000 | 32'(i);
	end

	assign wordIndex = address[indexWidth+1:2];

	// One LFSR bit per cycle decides the stall
	always @(negedge clk) begin
		lfsr = lfsrStep(lfsr);
		busy <= lfsr[0];
		if (enable)
			data <= rom[wordIndex];
	end

endmodule

//--- bench/rvCoreTb.sv
module rvCoreTb import rvCorePkg::*;;

	localparam logic [31:0] resetVector = 32'h0;
	localparam logic [31:0] programABase = 32'h000;
	localparam logic [31:0] programBBase = 32'h100;
	localparam logic [31:0] stepAddress = 32'h200;
	localparam int apbMargin = 1500;

	logic clk = 1'b0;
	logic rst;
	apbRequest apbIn;
	apbResponse apbOut;
	logic [31:0] imemAddress;
	logic imemEnable;
	logic [31:0] imemData;
	logic imemBusy;

	logic [31:0] image [256];
	bit placed [256];
	logic [31:0] modelRegs [32];
	logic [31:0] placeAddress;
	int wordCount = 0;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int cycleCount = 0;
	int cycleLimit = 1000000;
	bit expectIdle = 0;

	rvCore #(
		.resetVector(resetVector),
		.queueDepth(2)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.imemAddress(imemAddress),
		.imemEnable(imemEnable),
		.imemData(imemData),
		.imemBusy(imemBusy)
	);

	instructionMemoryModel #(
		.depth(256),
		.seed(32'hf6ca)
	) imem_i (
		.clk(clk),
		.address(imemAddress),
		.enable(imemEnable),
		.data(imemData),
		.busy(imemBusy)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles, the core never came back to halted", cycleCount);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Fetch request must hold while the memory stalls
	assert property (@(posedge clk) disable iff (rst)
		(imemEnable && imemBusy) |=> (imemEnable && $stable(imemAddress)))
	else begin
		$display("fetch request dropped or moved during a stall at %0t", $time);
		errorCount++;
	end

	assert property (@(posedge clk) expectIdle |-> !imemEnable)
	else begin
		$display("instruction fetch started while the core was idle at %0t", $time);
		errorCount++;
	end

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opcodeOp};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, opcodeOpImm};
	endfunction

	function automatic logic [31:0] encU(input logic [6:0] op, input logic [19:0] imm,
		input logic [4:0] rd);
		return {imm, rd, op};
	endfunction

	function automatic logic [15:0] regAddr(input int i);
		return addrRegisterBase + 16'(4 * i);
	endfunction

	function automatic logic [31:0] regPattern(input int i);
		return (32'(i) * 32'h2f6b1d37) ^ 32'hc3a55a3c;
	endfunction

	function automatic logic [31:0] byteMerge(input logic [31:0] old, input logic [31:0] value,
		input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old & ~mask) | (value & mask);
	endfunction

	task automatic emit(input logic [31:0] word);
		image[placeAddress[9:2]] = word;
		placed[placeAddress[9:2]] = 1'b1;
		placeAddress += 32'd4;
		wordCount++;
	endtask

	// Reference model of one retired instruction
	task automatic applyInstruction(input logic [31:0] w, input logic [31:0] pc, output bit ok);
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		a = modelRegs[w[19:15]];
		b = (op == 7'h33) ? modelRegs[w[24:20]] : {{20{w[31]}}, w[31:20]};
		ok = 1'b1;
		r = '0;
		if (op == 7'h37) begin
			r = {w[31:12], 12'h000};
		end else if (op == 7'h17) begin
			r = pc + {w[31:12], 12'h000};
		end else if (op == 7'h13 || op == 7'h33) begin
			if (op == 7'h33 && !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))))
				ok = 1'b0;
			if (op == 7'h13 && f3 == 3'd1 && f7 != 7'h00)
				ok = 1'b0;
			if (op == 7'h13 && f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)
				ok = 1'b0;
			case (f3)
				3'd0: r = (op == 7'h33 && f7 == 7'h20) ? a - b : a + b;
				3'd1: r = a << b[4:0];
				3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'd3: r = (a < b) ? 32'd1 : 32'd0;
				3'd4: r = a ^ b;
				3'd5: begin
					if (f7[5])
						r = $signed(a) >>> b[4:0];
					else
						r = a >> b[4:0];
				end
				3'd6: r = a | b;
				default: r = a & b;
			endcase
		end else begin
			ok = 1'b0;
		end
		if (ok && w[11:7] != 5'd0)
			modelRegs[w[11:7]] = r;
	endtask

	task automatic runModel(input logic [31:0] start, output logic [31:0] faultPc);
		logic [31:0] pc;
		bit ok;
		pc = start;
		ok = 1'b1;
		while (ok) begin
			applyInstruction(image[pc[9:2]], pc, ok);
			if (ok)
				pc += 32'd4;
		end
		faultPc = pc;
	endtask

	task automatic apbTransfer(input logic write, input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite = write;
		apbIn.paddr = addr;
		apbIn.pwdata = data;
		apbIn.pstrb = strb;
		@(negedge clk);
		apbIn.penable = 1'b1;
		// Response is stable between the falling and the rising edge
		#1;
		rdata = apbOut.prdata;
		err = apbOut.pslverr;
		@(negedge clk);
		apbIn.psel = 1'b0;
		apbIn.penable = 1'b0;
	endtask

	task automatic apbWrite(input logic [15:0] addr, input logic [31:0] data, input logic [3:0] strb,
		output logic err);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, data, strb, unused, err);
	endtask

	task automatic apbRead(input logic [15:0] addr, output logic [31:0] data, output logic err);
		apbTransfer(1'b0, addr, 32'h0, 4'h0, data, err);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		assert (got === expected)
		else begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkSlaveError(input logic got, input logic expected);
		assert (got === expected)
		else begin
			$display("[ERROR] %0t pslverr got %b expected %b", $time, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkRegisters();
		logic [31:0] data;
		logic err;
		for (int i = 0; i < 32; i++) begin
			apbRead(regAddr(i), data, err);
			checkSlaveError(err, 1'b0);
			check($sformatf("x%0d", i), data, modelRegs[i]);
		end
	endtask

	// Poll control bit1 until the core reports halted
	task automatic waitHalted();
		logic [31:0] data;
		logic err;
		data = '0;
		while (data[1] !== 1'b1)
			apbRead(addrControl, data, err);
	endtask

	task automatic reportTest(input int number, input string name, input int mark);
		if (errorCount == mark) begin
			testsPassed++;
			$display("test %0d %s: ok", number, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", number, name, errorCount - mark);
		end
	endtask

	initial begin
		logic [31:0] data;
		logic err;
		logic [31:0] faultPc;
		logic [31:0] stepWord;
		bit ok;
		int mark;

		rst = 1'b1;
		apbIn = '0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;

		placeAddress = programABase;
		emit(encI(12'hffb, 5'd2, 3'd0, 5'd1));
		emit(encI(12'd100, 5'd4, 3'd2, 5'd3));
		emit(encI(12'hfff, 5'd6, 3'd3, 5'd5));
		emit(encI(12'h5a5, 5'd8, 3'd4, 5'd7));
		emit(encI(12'hf00, 5'd10, 3'd6, 5'd9));
		emit(encI(12'h0ff, 5'd12, 3'd7, 5'd11));
		emit(encI({7'h00, 5'd7}, 5'd14, 3'd1, 5'd13));
		emit(encI({7'h00, 5'd13}, 5'd16, 3'd5, 5'd15));
		emit(encI({7'h20, 5'd21}, 5'd18, 3'd5, 5'd17));
		emit(encR(7'h00, 5'd3, 5'd1, 3'd0, 5'd19));
		emit(encR(7'h20, 5'd7, 5'd5, 3'd0, 5'd20));
		emit(encR(7'h00, 5'd11, 5'd9, 3'd1, 5'd21));
		emit(encR(7'h00, 5'd15, 5'd13, 3'd2, 5'd22));
		emit(encR(7'h00, 5'd19, 5'd17, 3'd3, 5'd23));
		emit(encR(7'h00, 5'd21, 5'd20, 3'd4, 5'd24));
		emit(encR(7'h00, 5'd24, 5'd19, 3'd5, 5'd25));
		emit(encR(7'h20, 5'd24, 5'd9, 3'd5, 5'd26));
		emit(encR(7'h00, 5'd26, 5'd25, 3'd6, 5'd27));
		emit(encR(7'h00, 5'd2, 5'd27, 3'd7, 5'd28));
		emit(encU(opcodeLui, 20'habcde, 5'd29));
		emit(encU(opcodeAuipc, 20'h12345, 5'd30));
		emit(encI(12'd7, 5'd1, 3'd0, 5'd0));
		emit(32'h00000000);

		// Second program faults on an OP word with funct7 01
		placeAddress = programBBase;
		emit(encU(opcodeLui, 20'h80000, 5'd31));
		emit(encI({7'h20, 5'd4}, 5'd31, 3'd5, 5'd1));
		emit(encR(7'h20, 5'd1, 5'd0, 3'd0, 5'd2));
		emit(encR(7'h00, 5'd31, 5'd2, 3'd3, 5'd3));
		emit(encR(7'h01, 5'd3, 5'd2, 3'd0, 5'd4));
		emit(encI(12'd1, 5'd5, 3'd0, 5'd5));

		stepWord = encI(12'hff9, 5'd3, 3'd0, 5'd5);
		placeAddress = stepAddress;
		emit(stepWord);

		cycleLimit = 10 * wordCount + apbMargin;

		@(negedge clk);
		for (int i = 0; i < 256; i++) begin
			if (placed[i])
				imem_i.rom[i] = image[i];
		end
		repeat (7) @(negedge clk);
		rst = 1'b0;
		expectIdle = 1'b1;

		mark = errorCount;
		apbRead(addrControl, data, err);
		checkSlaveError(err, 1'b0);
		check("control", data, 32'h2);
		apbRead(addrProgramCounter, data, err);
		checkSlaveError(err, 1'b0);
		check("programCounter", data, resetVector);
		apbRead(16'h0040, data, err);
		checkSlaveError(err, 1'b1);
		apbWrite(16'h0200, 32'h1234, 4'hf, err);
		checkSlaveError(err, 1'b1);
		reportTest(1, "reset state", mark);

		mark = errorCount;
		for (int i = 1; i < 32; i++) begin
			apbWrite(regAddr(i), regPattern(i), 4'hf, err);
			checkSlaveError(err, 1'b0);
			modelRegs[i] = regPattern(i);
		end
		apbWrite(regAddr(4), 32'h11223344, 4'b0101, err);
		checkSlaveError(err, 1'b0);
		modelRegs[4] = byteMerge(modelRegs[4], 32'h11223344, 4'b0101);
		apbWrite(regAddr(9), 32'hcafef00d, 4'b1000, err);
		checkSlaveError(err, 1'b0);
		modelRegs[9] = byteMerge(modelRegs[9], 32'hcafef00d, 4'b1000);
		apbWrite(regAddr(0), 32'hffffffff, 4'hf, err);
		checkSlaveError(err, 1'b0);
		checkRegisters();
		reportTest(2, "register access while halted", mark);

		mark = errorCount;
		expectIdle = 1'b0;
		apbWrite(addrProgramCounter, stepAddress, 4'hf, err);
		checkSlaveError(err, 1'b0);
		apbWrite(addrControl, 32'h2, 4'h1, err);
		checkSlaveError(err, 1'b0);
		waitHalted();
		applyInstruction(stepWord, stepAddress, ok);
		apbRead(addrProgramCounter, data, err);
		check("programCounter", data, stepAddress + 32'd4);
		apbRead(addrInstruction, data, err);
		check("instruction", data, stepWord);
		apbRead(regAddr(5), data, err);
		check("x5", data, modelRegs[5]);
		apbRead(addrControl, data, err);
		check("control", data, 32'h2);
		reportTest(3, "single step", mark);

		mark = errorCount;
		apbWrite(addrProgramCounter, programABase, 4'hf, err);
		checkSlaveError(err, 1'b0);
		apbWrite(addrControl, 32'h1, 4'h1, err);
		checkSlaveError(err, 1'b0);
		// x31 is untouched by the program, so the final compare sees any leak
		apbWrite(regAddr(31), 32'h0bad0bad, 4'hf, err);
		checkSlaveError(err, 1'b1);
		apbRead(regAddr(31), data, err);
		checkSlaveError(err, 1'b1);
		apbRead(addrProgramCounter, data, err);
		checkSlaveError(err, 1'b1);
		reportTest(4, "register access while running", mark);

		mark = errorCount;
		waitHalted();
		runModel(programABase, faultPc);
		apbRead(addrControl, data, err);
		check("control", data, 32'h6);
		apbRead(addrProgramCounter, data, err);
		check("programCounter", data, faultPc);
		checkRegisters();
		apbWrite(addrControl, 32'h1, 4'h1, err);
		checkSlaveError(err, 1'b1);
		apbRead(addrControl, data, err);
		check("control", data, 32'h6);
		reportTest(5, "full program under stalls", mark);

		mark = errorCount;
		apbWrite(addrControl, 32'h4, 4'h1, err);
		checkSlaveError(err, 1'b0);
		apbWrite(addrProgramCounter, programBBase, 4'hf, err);
		checkSlaveError(err, 1'b0);
		apbRead(addrControl, data, err);
		check("control", data, 32'h2);
		apbWrite(addrControl, 32'h1, 4'h1, err);
		checkSlaveError(err, 1'b0);
		waitHalted();
		runModel(programBBase, faultPc);
		apbRead(addrControl, data, err);
		check("control", data, 32'h6);
		apbRead(addrProgramCounter, data, err);
		check("programCounter", data, faultPc);
		checkRegisters();
		reportTest(6, "second program after error clear", mark);

		$display("tests passed %0d, tests failed %0d, failed checks %0d",
			testsPassed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- rvCore.f
src/rvCorePkg.sv
src/managementPort.sv
src/fetchUnit.sv
src/instructionQueue.sv
src/executeUnit.sv
src/rvCore.sv
bench/instructionMemoryModel.sv
bench/rvCoreTb.sv
